// File: cpu_testdata.txt
# I <byte address hex> <instruction word hex>   then the mnemonic
# E <test> <pc hex> <rd_we> <rd dec> <data hex> <cycles since previous commit, 0 = not checked>
I 00000000 00500093  addi x1, x0, 5
I 00000004 00c00113  addi x2, x0, 12
I 00000008 123451b7  lui  x3, 0x12345
I 0000000c 00208233  add  x4, x1, x2
I 00000010 401182b3  sub  x5, x3, x1
I 00000014 0051f333  and  x6, x3, x5
I 00000018 001363b3  or   x7, x6, x1
I 0000001c 0063c433  xor  x8, x7, x6
I 00000020 06408013  addi x0, x1, 100
I 00000024 008004b3  add  x9, x0, x8
I 00000028 00940663  beq  x8, x9, +12 taken
I 0000002c 00100513  addi x10, x0, 1 squashed
I 00000030 00200513  addi x10, x0, 2 squashed
I 00000034 00209663  bne  x1, x2, +12 taken
I 00000038 00300513  addi x10, x0, 3 squashed
I 0000003c 00400513  addi x10, x0, 4 squashed
I 00000040 00208663  beq  x1, x2, +12 not taken
I 00000044 00c005ef  jal  x11, +12
I 00000048 00500513  addi x10, x0, 5 squashed
I 0000004c 00600513  addi x10, x0, 6 squashed
I 00000050 00a58633  add  x12, x11, x10
I 00000054 00460693  addi x13, x12, 4
I 00000058 0000006f  jal  x0, 0
E 1 00000000 1 1  00000005 0
E 1 00000004 1 2  0000000c 1
E 2 00000008 1 3  12345000 1
E 2 0000000c 1 4  00000011 1
E 2 00000010 1 5  12344ffb 1
E 3 00000014 1 6  12344000 1
E 3 00000018 1 7  12344005 1
E 3 0000001c 1 8  00000005 1
E 4 00000020 0 0  00000000 1
E 4 00000024 1 9  00000005 1
E 5 00000028 0 0  00000000 1
E 5 00000034 0 0  00000000 3
E 5 00000040 0 0  00000000 3
E 5 00000044 1 11 00000048 1
E 5 00000050 1 12 00000048 3
E 6 00000054 1 13 0000004c 1
E 6 00000058 0 0  00000000 1
E 6 00000058 0 0  00000000 3
E 6 00000058 0 0  00000000 3

// File: project.f
cpu_pkg.sv
gpr.sv
ifu.sv
idu.sv
alu.sv
exu.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu_top.sv

// File: Makefile
# Verilator build and run of the core testbench
TOP := tb_cpu_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_cpu_top.sv
// testbench for the three-stage RV32I core
// loads the program and the expected commits from the data file, serves the
// instruction fetches from an array and checks every commit in program order
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

    localparam int    MEM_DEPTH  = 256;
    localparam int    WAIT_LIMIT = 20;
    localparam string DATA_FILE  = "cpu_testdata.txt";

    // one expected commit, gap is the cycle count since the previous commit
    typedef struct packed {
        int              test;
        logic [XLEN-1:0] pc;
        logic            rd_we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        int              gap;
    } expect_t;

    logic            clk;
    logic            rst_i;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_data;
    commit_t         commit;

    logic [XLEN-1:0] imem [0:MEM_DEPTH-1];
    expect_t         expected [$];
    int              errors;
    int              test_errors;
    int              tests_run;
    int              tests_failed;

    cpu_top dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .imem_addr_o(imem_addr),
        .imem_data_i(imem_data),
        .commit_o   (commit)
    );

    always #2 clk = ~clk;

    // word addressed, answers in the same cycle
    assign imem_data = imem[imem_addr[9:2]];

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] exp_val);
        if (actual !== exp_val) begin
            $display("MISMATCH time %0d ns: %s expected %h actual %h",
                     $time, name, exp_val, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_testdata();
        int              fd;
        int              n;
        int              t;
        int              we;
        int              rd;
        int              gap;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] word;
        string           line;
        expect_t         e;
        // unused words hold addi x0, x0, index
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem[i] = 32'h0000_0013 | (i << 20);
        end
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open %s", DATA_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] == "I") begin
                n = $sscanf(line, "I %h %h", addr, word);
                if (n != 2) begin
                    $display("ERROR: bad program line in %s: %s", DATA_FILE, line);
                    errors++;
                end
                imem[addr[9:2]] = word;
            end else if (n > 0 && line[0] == "E") begin
                n = $sscanf(line, "E %d %h %d %d %h %d", t, addr, we, rd, word, gap);
                if (n != 6) begin
                    $display("ERROR: bad expect line in %s: %s", DATA_FILE, line);
                    errors++;
                end
                e.test  = t;
                e.pc    = addr;
                e.rd_we = we[0];
                e.rd    = rd[4:0];
                e.data  = word;
                e.gap   = gap;
                expected.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // samples on the falling edge, where commit_o is stable
    task automatic wait_for_commit(output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!commit.valid && waited < WAIT_LIMIT);
    endtask

    task automatic report_test(input int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", num);
        end else begin
            tests_failed++;
            $display("test %0d: %0d error(s)", num, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        expect_t e;
        int      waited;
        int      current;
        clk          = 1'b0;
        rst_i        = 1'b1;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        current      = 1;
        load_testdata();
        if (expected.size() == 0) begin
            $display("ERROR: no expected commits found in %s", DATA_FILE);
            errors++;
        end
        // quiet core and reset pc while reset is held
        repeat (5) begin
            @(negedge clk);
            check_value("commit_o.valid", 32'(commit.valid), 32'd0);
            check_value("imem_addr_o", imem_addr, RESET_PC);
        end
        rst_i = 1'b0;
        check_value("commit_o.valid", 32'(commit.valid), 32'd0);
        check_value("imem_addr_o", imem_addr, RESET_PC);

        for (int i = 0; i < expected.size(); i++) begin
            e = expected[i];
            if (e.test != current) begin
                report_test(current);
                current = e.test;
            end
            wait_for_commit(waited);
            if (!commit.valid) begin
                $display("ERROR: test %0d saw no commit for pc %h within %0d cycles",
                         current, e.pc, WAIT_LIMIT);
                errors++;
                test_errors++;
                break;
            end
            check_value("commit_o.pc", commit.pc, e.pc);
            check_value("commit_o.rd_we", 32'(commit.rd_we), 32'(e.rd_we));
            // rd and data only matter when the register file is written
            if (e.rd_we) begin
                check_value("commit_o.rd", 32'(commit.rd), 32'(e.rd));
                check_value("commit_o.data", commit.data, e.data);
            end
            if (e.gap != 0) begin
                check_value("cycles since last commit", 32'(waited), 32'(e.gap));
            end
        end
        report_test(current);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: cpu_assertions.sv
// concurrent checks on the pipeline rules of the execute unit
// bound into exu, so every instance of the core carries them
`timescale 1ns/1ps

module cpu_assertions import cpu_pkg::*; (
    input logic    clk,
    input logic    rst_i,
    input decode_t decode_i,
    input commit_t commit_i,
    input logic    redirect_i
);

    // the record behind a taken branch is always squashed
    redirect_single: assert property (@(posedge clk) disable iff (rst_i)
        redirect_i |=> !redirect_i)
        else $error("redirect high for two consecutive cycles");

    x0_never_written: assert property (@(posedge clk) disable iff (rst_i)
        !(commit_i.rd_we && (commit_i.rd == '0)))
        else $error("commit shows a write to x0");

    flush_after_redirect: assert property (@(posedge clk) disable iff (rst_i)
        redirect_i |=> !decode_i.valid)
        else $error("valid decode record in the cycle after a redirect");

endmodule

bind exu cpu_assertions u_cpu_assertions (
    .clk       (clk),
    .rst_i     (rst_i),
    .decode_i  (decode_i),
    .commit_i  (commit_o),
    .redirect_i(redirect_o)
);

// File: cpu_top.sv
// top of the three-stage RV32I core
// fetch port reads the instruction memory combinationally; each retired
// instruction shows on the commit port for one cycle
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output commit_t         commit_o
);

    fetch_t                fetch;
    decode_t               decode;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;

    ifu u_ifu (
        .clk          (clk),
        .rst_i        (rst_i),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .fetch_o      (fetch)
    );

    // redirect also squashes the instruction being decoded
    idu u_idu (
        .clk       (clk),
        .rst_i     (rst_i),
        .fetch_i   (fetch),
        .flush_i   (redirect),
        .rs1_o     (rs1_addr),
        .rs2_o     (rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .decode_o  (decode)
    );

    // write-back straight from the commit register
    gpr u_gpr (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (commit_o.valid & commit_o.rd_we),
        .waddr_i (commit_o.rd),
        .wdata_i (commit_o.data),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    exu u_exu (
        .clk          (clk),
        .rst_i        (rst_i),
        .decode_i     (decode),
        .commit_o     (commit_o),
        .redirect_o   (redirect),
        .redirect_pc_o(redirect_pc)
    );

endmodule

// File: exu.sv
// execute unit: forwarding, ALU, branch and jump resolution, commit register
// a taken branch or jal raises the redirect in the same cycle it is executed
`timescale 1ns/1ps

module exu import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  decode_t         decode_i,
    output commit_t         commit_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    commit_t         commit_q;
    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            equal;
    logic            taken;

    // previous instruction sits in the commit register
    // older results arrive through the register file write-through
    assign fwd_a = commit_q.valid && commit_q.rd_we && (decode_i.rs1 != '0)
                   && (commit_q.rd == decode_i.rs1);
    assign fwd_b = commit_q.valid && commit_q.rd_we && (decode_i.rs2 != '0)
                   && (commit_q.rd == decode_i.rs2);

    assign op_a    = fwd_a ? commit_q.data : decode_i.rs1_data;
    assign rs2_val = fwd_b ? commit_q.data : decode_i.rs2_data;
    assign op_b    = decode_i.b_is_imm ? decode_i.imm : rs2_val;

    alu u_alu (
        .op_a_i  (op_a),
        .op_b_i  (op_b),
        .alu_op_i(decode_i.alu_op),
        .result_o(alu_result),
        .equal_o (equal)
    );

    always_comb begin
        case (decode_i.br_op)
            BR_EQ:   taken = equal;
            BR_NE:   taken = !equal;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = decode_i.valid && taken;
    assign redirect_pc_o = decode_i.pc + decode_i.imm;

    always_ff @(posedge clk) begin
        commit_q.pc   <= decode_i.pc;
        commit_q.rd   <= decode_i.rd;
        // jal links the return address
        commit_q.data <= (decode_i.br_op == BR_JAL) ? decode_i.pc + 32'd4 : alu_result;
        if (rst_i) begin
            commit_q.valid <= 1'b0;
            commit_q.rd_we <= 1'b0;
        end else begin
            commit_q.valid <= decode_i.valid;
            commit_q.rd_we <= decode_i.valid && decode_i.rd_we;
        end
    end

    assign commit_o = commit_q;

endmodule

// File: alu.sv
// combinational ALU for the integer subset
// also reports operand equality for the branch decision in execute
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  alu_op_e         alu_op_i,
    output logic [XLEN-1:0] result_o,
    output logic            equal_o
);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op_a_i + op_b_i;
            ALU_SUB:    result_o = op_a_i - op_b_i;
            ALU_AND:    result_o = op_a_i & op_b_i;
            ALU_OR:     result_o = op_a_i | op_b_i;
            ALU_XOR:    result_o = op_a_i ^ op_b_i;
            // lui carries its value in operand b
            ALU_PASS_B: result_o = op_b_i;
            default:    result_o = '0;
        endcase
    end

    assign equal_o = (op_a_i == op_b_i);

endmodule

// File: idu.sv
// decode unit: splits the fetched word, reads the register file and
// registers the record for execute; unknown encodings become no-ops
`timescale 1ns/1ps

module idu import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  fetch_t                fetch_i,
    input  logic                  flush_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output decode_t               decode_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_j;
    logic [XLEN-1:0]       imm;
    logic                  b_is_imm;
    alu_op_e               alu_op;
    br_op_e                br_op;
    logic                  writes_rd;
    decode_t               decode_q;

    assign opcode = fetch_i.instr[6:0];
    assign rd     = fetch_i.instr[11:7];
    assign funct3 = fetch_i.instr[14:12];
    assign rs1_o  = fetch_i.instr[19:15];
    assign rs2_o  = fetch_i.instr[24:20];
    assign funct7 = fetch_i.instr[31:25];

    assign imm_i = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
    assign imm_u = {fetch_i.instr[31:12], 12'b0};
    assign imm_b = {{19{fetch_i.instr[31]}}, fetch_i.instr[31], fetch_i.instr[7],
                    fetch_i.instr[30:25], fetch_i.instr[11:8], 1'b0};
    assign imm_j = {{11{fetch_i.instr[31]}}, fetch_i.instr[31], fetch_i.instr[19:12],
                    fetch_i.instr[20], fetch_i.instr[30:21], 1'b0};

    always_comb begin
        imm       = '0;
        b_is_imm  = 1'b0;
        alu_op    = ALU_ADD;
        br_op     = BR_NONE;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                // only addi in this subset
                if (funct3 == 3'b000) begin
                    imm       = imm_i;
                    b_is_imm  = 1'b1;
                    writes_rd = 1'b1;
                end
            end
            OPC_LUI: begin
                imm       = imm_u;
                b_is_imm  = 1'b1;
                alu_op    = ALU_PASS_B;
                writes_rd = 1'b1;
            end
            OPC_OP: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_111: alu_op = ALU_AND;
                    default:         writes_rd = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    br_op = BR_EQ;
                end else if (funct3 == 3'b001) begin
                    br_op = BR_NE;
                end
            end
            OPC_JAL: begin
                imm       = imm_j;
                br_op     = BR_JAL;
                writes_rd = 1'b1;
            end
            default: begin
                // no-op that still retires
            end
        endcase
    end

    always_ff @(posedge clk) begin
        decode_q.pc       <= fetch_i.pc;
        decode_q.rs1      <= rs1_o;
        decode_q.rs2      <= rs2_o;
        decode_q.rs1_data <= rs1_data_i;
        decode_q.rs2_data <= rs2_data_i;
        decode_q.imm      <= imm;
        decode_q.b_is_imm <= b_is_imm;
        decode_q.alu_op   <= alu_op;
        decode_q.br_op    <= br_op;
        // x0 destinations never show a write
        decode_q.rd_we    <= writes_rd && (rd != '0);
        decode_q.rd       <= (writes_rd && (rd != '0)) ? rd : '0;
        if (rst_i) begin
            decode_q.valid <= 1'b0;
        end else begin
            decode_q.valid <= fetch_i.valid && !flush_i;
        end
    end

    assign decode_o = decode_q;

endmodule

// File: ifu.sv
// fetch unit: program counter, instruction memory address and fetch register
// a redirect from execute loads the target and drops the word fetched in that cycle
`timescale 1ns/1ps

module ifu import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output fetch_t          fetch_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    fetch_t          fetch_q;

    assign pc_next = redirect_i ? redirect_pc_i : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // memory answers in the same cycle, so the word is captured with its pc
    always_ff @(posedge clk) begin
        fetch_q.pc    <= pc_q;
        fetch_q.instr <= imem_data_i;
        if (rst_i) begin
            fetch_q.valid <= 1'b0;
        end else begin
            // word at the old path is squashed
            fetch_q.valid <= !redirect_i;
        end
    end

    assign imem_addr_o = pc_q;
    assign fetch_o     = fetch_q;

endmodule

// File: gpr.sv
// integer register file with two read ports and one write port
// x0 reads as zero; a read of the index being written returns the write data
`timescale 1ns/1ps

module gpr import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    // storage for x1 to x31 only
    logic [XLEN-1:0] regs_q [1:31];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] raddr);
        logic [XLEN-1:0] value;
        if (raddr == '0) begin
            value = '0;
        end else if (we_i && (waddr_i == raddr)) begin
            // write-through so the retiring result is seen in the same cycle
            value = wdata_i;
        end else begin
            value = regs_q[raddr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // reevaluated on the write port and the storage as well as the read index
    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

// File: cpu_pkg.sv
// shared widths, opcodes, operation codes and pipeline records of the RV32I core
// every unit of the core imports this package with a wildcard import
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_op_e;

    // fetch to decode
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic                  b_is_imm;
        alu_op_e               alu_op;
        br_op_e                br_op;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd;
    } decode_t;

    // one retired instruction
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } commit_t;

endpackage
